// File: common/tuart_pkg.sv
// Shared definitions for the tiny UART subsystem
// Imported by the transmitter and the flow-control decoder

package tuart_pkg;

  // Flow-control state held by the transmitter
  typedef enum logic {
    XON  = 1'b0,
    XOFF = 1'b1
  } xctrl_t;

  // Software flow-control characters, zero-extended to the word width where used
  localparam logic [7:0] XON_CHAR  = 8'h11;
  localparam logic [7:0] XOFF_CHAR = 8'h13;

endpackage

// File: common/flow_ctrl_if.sv
// Flow-control strobes from the XON/XOFF decoder to the transmitter
// stb is a single-cycle pulse, with exactly one of xon/xoff high

`timescale 1ns/1ps

interface flow_ctrl_if;

  logic stb;
  logic xon;
  logic xoff;

  modport master (
    output stb,
    output xon,
    output xoff
  );

  modport slave (
    input stb,
    input xon,
    input xoff
  );

endinterface

// File: common/rx_byte_if.sv
// Received words from the UART receiver to the flow-control decoder
// No back-pressure, so the sink takes every stb pulse

`timescale 1ns/1ps

interface rx_byte_if #(
  parameter int WORD_BITS = 8
);

  logic                 stb;
  logic [WORD_BITS-1:0] data;
  logic                 frame_err;

  modport source (
    output stb,
    output data,
    output frame_err
  );

  modport sink (
    input stb,
    input data,
    input frame_err
  );

endinterface

// File: tuart_rx/tuart_rx.sv
// UART receiver, 1 start bit, WORD_BITS data bits LSB first, 1 stop bit
// Reports each word with a frame-error flag on a single-cycle stb

`timescale 1ns/1ps

module tuart_rx #(
  parameter int WORD_BITS      = 8,
  parameter int CLK_PER_SAMPLE = 10
) (
  input  logic       clk_i,
  input  logic       rst_in,
  input  logic       rx_i,
  rx_byte_if.source  rx_o
);

  localparam int BIT_W  = $clog2(WORD_BITS);
  localparam int TIME_W = $clog2(CLK_PER_SAMPLE);

  localparam logic [TIME_W-1:0] TIME_LAST = TIME_W'(CLK_PER_SAMPLE - 1);
  localparam logic [TIME_W-1:0] TIME_HALF = TIME_W'(CLK_PER_SAMPLE / 2 - 1);
  localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(WORD_BITS - 1);

  typedef enum logic [1:0] {RX_IDLE, RX_START, RX_DATA, RX_STOP} state_t;

  state_t               state;
  logic                 rx_meta;
  logic                 rx_sync;
  logic                 rx_prev;
  logic [TIME_W-1:0]    time_cnt;
  logic [BIT_W-1:0]     bit_cnt;
  logic [WORD_BITS-1:0] shft_reg;
  logic                 stb_q;
  logic                 frame_err_q;

  // Two-stage synchroniser plus one stage for edge detection
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx_i;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state    <= RX_IDLE;
      time_cnt <= '0;
      bit_cnt  <= '0;
      stb_q    <= 1'b0;
    end else begin
      stb_q <= 1'b0;
      case (state)
        RX_IDLE: begin
          // Falling edge, wait half a bit to reach the start bit centre
          if (rx_prev && !rx_sync) begin
            state    <= RX_START;
            time_cnt <= TIME_HALF;
          end
        end

        RX_START: begin
          time_cnt <= time_cnt - 1'b1;
          if (time_cnt == '0) begin
            time_cnt <= TIME_LAST;
            bit_cnt  <= BIT_LAST;
            // Line high again means a glitch, not a start bit
            state    <= rx_sync ? RX_IDLE : RX_DATA;
          end
        end

        RX_DATA: begin
          time_cnt <= time_cnt - 1'b1;
          if (time_cnt == '0) begin
            time_cnt <= TIME_LAST;
            bit_cnt  <= bit_cnt - 1'b1;
            if (bit_cnt == '0) begin
              state <= RX_STOP;
            end
          end
        end

        RX_STOP: begin
          time_cnt <= time_cnt - 1'b1;
          if (time_cnt == '0) begin
            stb_q <= 1'b1;
            state <= RX_IDLE;
          end
        end

        default: state <= RX_IDLE;
      endcase
    end
  end

  // Data and flag sampled at bit centres
  always_ff @(posedge clk_i) begin
    if (state == RX_DATA && time_cnt == '0) begin
      shft_reg <= {rx_sync, shft_reg[WORD_BITS-1:1]};
    end
    if (state == RX_STOP && time_cnt == '0) begin
      frame_err_q <= !rx_sync;
    end
  end

  assign rx_o.stb       = stb_q;
  assign rx_o.data      = shft_reg;
  assign rx_o.frame_err = frame_err_q;

endmodule

// File: hdl/xon_xoff_decode.sv
// Splits XON/XOFF characters out of the received word stream
// Clean flow characters become flow strobes, everything else is forwarded

`timescale 1ns/1ps

module xon_xoff_decode import tuart_pkg::*; #(
  parameter int WORD_BITS = 8
) (
  input  logic                 clk_i,
  input  logic                 rst_in,
  rx_byte_if.sink              byte_i,
  flow_ctrl_if.master          xctrl_o,
  output logic                 stb_o,
  output logic [WORD_BITS-1:0] data_o,
  output logic                 frame_err_o
);

  logic is_xon;
  logic is_xoff;
  logic is_flow;

  assign is_xon  = (byte_i.data == WORD_BITS'(XON_CHAR));
  assign is_xoff = (byte_i.data == WORD_BITS'(XOFF_CHAR));
  // Flow characters with a bad stop bit are passed on as data
  assign is_flow = !byte_i.frame_err && (is_xon || is_xoff);

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      xctrl_o.stb <= 1'b0;
      stb_o       <= 1'b0;
    end else begin
      xctrl_o.stb <= byte_i.stb && is_flow;
      stb_o       <= byte_i.stb && !is_flow;
    end
  end

  always_ff @(posedge clk_i) begin
    if (byte_i.stb && is_flow) begin
      xctrl_o.xon  <= is_xon;
      xctrl_o.xoff <= is_xoff;
    end
    if (byte_i.stb && !is_flow) begin
      data_o      <= byte_i.data;
      frame_err_o <= byte_i.frame_err;
    end
  end

endmodule

// File: tuart_tx/tuart_tx.sv
// UART transmitter for multi-word commands, 1 start bit, 1 stop bit
// A command starts only while the flow state is XON

`timescale 1ns/1ps

module tuart_tx import tuart_pkg::*; #(
  parameter int WORD_BITS      = 8,
  parameter int CMD_WORDS      = 4,
  parameter int CLK_PER_SAMPLE = 10
) (
  input  logic                           clk_i,
  input  logic                           rst_in,
  input  logic                           stb_i,
  output logic                           rdy_o,
  output logic                           tx_o,
  flow_ctrl_if.slave                     xctrl_i,
  input  logic [CMD_WORDS*WORD_BITS-1:0] data_i
);

  localparam int BIT_W  = $clog2(WORD_BITS);
  localparam int WCNT_W = (CMD_WORDS > 1) ? $clog2(CMD_WORDS) : 1;
  localparam int TIME_W = $clog2(CLK_PER_SAMPLE);

  localparam logic [TIME_W-1:0] TIME_LAST = TIME_W'(CLK_PER_SAMPLE - 1);
  localparam logic [BIT_W-1:0]  BIT_LAST  = BIT_W'(WORD_BITS - 1);
  localparam logic [WCNT_W-1:0] WORD_LAST = WCNT_W'(CMD_WORDS - 1);

  typedef enum logic [1:0] {IDLE, TX_START, TX_DATA, TX_STOP} state_t;

  state_t                         state, state_next;
  logic [BIT_W-1:0]               bit_cnt, bit_cnt_next;
  logic [WCNT_W-1:0]              word_cnt, word_cnt_next;
  logic [TIME_W-1:0]              time_cnt, time_cnt_next;
  logic [WORD_BITS-1:0]           shft_reg, shft_reg_next;
  logic [CMD_WORDS*WORD_BITS-1:0] cmd_q;
  xctrl_t                         r_xctrl;
  logic                           accept;

  assign accept = (state == IDLE) && stb_i && (r_xctrl == XON);
  assign rdy_o  = (state == IDLE);

  always_comb begin
    case (state)
      TX_START: tx_o = 1'b0;
      TX_DATA:  tx_o = shft_reg[0];
      default:  tx_o = 1'b1;
    endcase
  end

  always_comb begin
    state_next    = state;
    bit_cnt_next  = bit_cnt;
    word_cnt_next = word_cnt;
    time_cnt_next = time_cnt;
    shft_reg_next = shft_reg;

    case (state)
      IDLE: begin
        if (accept) begin
          state_next    = TX_START;
          word_cnt_next = WORD_LAST;
          time_cnt_next = TIME_LAST;
        end
      end

      TX_START: begin
        time_cnt_next = time_cnt - 1'b1;
        if (time_cnt == '0) begin
          // Most significant word goes first
          state_next    = TX_DATA;
          time_cnt_next = TIME_LAST;
          bit_cnt_next  = BIT_LAST;
          shft_reg_next = cmd_q[word_cnt*WORD_BITS +: WORD_BITS];
        end
      end

      TX_DATA: begin
        time_cnt_next = time_cnt - 1'b1;
        if (time_cnt == '0) begin
          time_cnt_next = TIME_LAST;
          bit_cnt_next  = bit_cnt - 1'b1;
          shft_reg_next = shft_reg >> 1;
          if (bit_cnt == '0) begin
            state_next = TX_STOP;
          end
        end
      end

      TX_STOP: begin
        time_cnt_next = time_cnt - 1'b1;
        if (time_cnt == '0) begin
          time_cnt_next = TIME_LAST;
          word_cnt_next = word_cnt - 1'b1;
          state_next    = (word_cnt == '0) ? IDLE : TX_START;
        end
      end

      default: state_next = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      state    <= IDLE;
      bit_cnt  <= '0;
      word_cnt <= '0;
      time_cnt <= '0;
    end else begin
      state    <= state_next;
      bit_cnt  <= bit_cnt_next;
      word_cnt <= word_cnt_next;
      time_cnt <= time_cnt_next;
    end
  end

  // Command payload, held for the whole transfer
  always_ff @(posedge clk_i) begin
    shft_reg <= shft_reg_next;
    if (accept) begin
      cmd_q <= data_i;
    end
  end

  // Flow state only gates the next acceptance
  always_ff @(posedge clk_i) begin
    if (!rst_in) begin
      r_xctrl <= XON;
    end else if (xctrl_i.stb && xctrl_i.xon) begin
      r_xctrl <= XON;
    end else if (xctrl_i.stb && xctrl_i.xoff) begin
      r_xctrl <= XOFF;
    end
  end

endmodule

// File: hdl/tuart_top.sv
// Tiny UART top level: receiver, XON/XOFF decoder and transmitter
// Parameters set here are passed down to every block

`timescale 1ns/1ps

module tuart_top #(
  parameter int WORD_BITS      = 8,
  parameter int CMD_WORDS      = 4,
  parameter int CLK_PER_SAMPLE = 10
) (
  input  logic                           clk_i,
  input  logic                           rst_in,
  input  logic                           tx_stb_i,
  input  logic [CMD_WORDS*WORD_BITS-1:0] tx_data_i,
  output logic                           tx_rdy_o,
  output logic                           tx_o,
  input  logic                           rx_i,
  output logic                           rx_stb_o,
  output logic [WORD_BITS-1:0]           rx_data_o,
  output logic                           rx_frame_err_o
);

  rx_byte_if #(.WORD_BITS(WORD_BITS)) rx_byte ();
  flow_ctrl_if                        xctrl ();

  tuart_rx #(
    .WORD_BITS      (WORD_BITS),
    .CLK_PER_SAMPLE (CLK_PER_SAMPLE)
  ) u_rx (
    .clk_i  (clk_i),
    .rst_in (rst_in),
    .rx_i   (rx_i),
    .rx_o   (rx_byte.source)
  );

  xon_xoff_decode #(
    .WORD_BITS (WORD_BITS)
  ) u_decode (
    .clk_i       (clk_i),
    .rst_in      (rst_in),
    .byte_i      (rx_byte.sink),
    .xctrl_o     (xctrl.master),
    .stb_o       (rx_stb_o),
    .data_o      (rx_data_o),
    .frame_err_o (rx_frame_err_o)
  );

  tuart_tx #(
    .WORD_BITS      (WORD_BITS),
    .CMD_WORDS      (CMD_WORDS),
    .CLK_PER_SAMPLE (CLK_PER_SAMPLE)
  ) u_tx (
    .clk_i   (clk_i),
    .rst_in  (rst_in),
    .stb_i   (tx_stb_i),
    .rdy_o   (tx_rdy_o),
    .tx_o    (tx_o),
    .xctrl_i (xctrl.slave),
    .data_i  (tx_data_i)
  );

endmodule

// File: sim/tuart_props.sv
// Concurrent checks on the UART top-level ports
// Bound into every tuart_top instance

`timescale 1ns/1ps

module tuart_props (
  input logic clk_i,
  input logic rst_in,
  input logic tx_stb_i,
  input logic tx_rdy_o,
  input logic tx_o,
  input logic rx_stb_o
);

  // Idle line and ready level once reset has been seen
  reset_idle_a: assert property (@(posedge clk_i) !rst_in |=> (tx_rdy_o && tx_o))
    else $error("tx_rdy_o or tx_o low during or right after reset");

  // Accepted strobe shows up as ready dropping one cycle later
  start_bit_a: assert property (@(posedge clk_i) disable iff (!rst_in)
    ($past(tx_rdy_o && tx_stb_i) && !tx_rdy_o) |-> !tx_o)
    else $error("tx_o not low in the cycle after an accepted strobe");

  rx_stb_pulse_a: assert property (@(posedge clk_i) disable iff (!rst_in)
    rx_stb_o |=> !rx_stb_o)
    else $error("rx_stb_o high in two consecutive cycles");

endmodule

bind tuart_top tuart_props u_props (
  .clk_i    (clk_i),
  .rst_in   (rst_in),
  .tx_stb_i (tx_stb_i),
  .tx_rdy_o (tx_rdy_o),
  .tx_o     (tx_o),
  .rx_stb_o (rx_stb_o)
);

// File: sim/tuart_tb.sv
// Testbench for the tiny UART top level
// Random commands and received words are checked against a serial line model

`timescale 1ns/1ps

module tuart_tb;

  localparam int WORD_BITS      = 8;
  localparam int CMD_WORDS      = 4;
  localparam int CLK_PER_SAMPLE = 10;
  localparam int CMD_CYCLES     = CMD_WORDS * (WORD_BITS + 2) * CLK_PER_SAMPLE;

  localparam logic [WORD_BITS-1:0] XON_WORD  = WORD_BITS'(8'h11);
  localparam logic [WORD_BITS-1:0] XOFF_WORD = WORD_BITS'(8'h13);

  logic                           clk;
  logic                           rst_in;
  logic                           tx_stb_i;
  logic [CMD_WORDS*WORD_BITS-1:0] tx_data_i;
  logic                           tx_rdy_o;
  logic                           tx_o;
  logic                           rx_i;
  logic                           rx_stb_o;
  logic [WORD_BITS-1:0]           rx_data_o;
  logic                           rx_frame_err_o;

  int                   cyc = 0;
  string                test_name;
  // Expected forwarded words with frame_err in the top bit
  logic [WORD_BITS:0]   rx_exp[$];
  logic [WORD_BITS-1:0] word;
  logic [CMD_WORDS*WORD_BITS-1:0] cmd;
  int                   i;

  always #4 clk = ~clk;

  always @(posedge clk) cyc <= cyc + 1;

  tuart_top #(
    .WORD_BITS      (WORD_BITS),
    .CMD_WORDS      (CMD_WORDS),
    .CLK_PER_SAMPLE (CLK_PER_SAMPLE)
  ) uut (
    .clk_i          (clk),
    .rst_in         (rst_in),
    .tx_stb_i       (tx_stb_i),
    .tx_data_i      (tx_data_i),
    .tx_rdy_o       (tx_rdy_o),
    .tx_o           (tx_o),
    .rx_i           (rx_i),
    .rx_stb_o       (rx_stb_o),
    .rx_data_o      (rx_data_o),
    .rx_frame_err_o (rx_frame_err_o)
  );

  task automatic report_mismatch(input string what, input logic [63:0] expv,
                                 input logic [63:0] actv);
    $display("error %s, %s: expected %0h, actual %0h", test_name, what, expv, actv);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic report_failure(input string what);
    $display("%s: %s", test_name, what);
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  function automatic logic [CMD_WORDS*WORD_BITS-1:0] random_cmd();
    logic [CMD_WORDS*WORD_BITS-1:0] c;
    int k;
    for (k = 0; k < CMD_WORDS; k++) begin
      c[k*WORD_BITS +: WORD_BITS] = WORD_BITS'($urandom);
    end
    return c;
  endfunction

  // Any word except the two flow-control characters
  function automatic logic [WORD_BITS-1:0] random_data_word();
    logic [WORD_BITS-1:0] w;
    w = WORD_BITS'($urandom);
    while (w == XON_WORD || w == XOFF_WORD) begin
      w = WORD_BITS'($urandom);
    end
    return w;
  endfunction

  task automatic drive_rx_word(input logic [WORD_BITS-1:0] w, input logic stop_bit);
    int b;
    @(negedge clk);
    rx_i = 1'b0;
    repeat (CLK_PER_SAMPLE) @(negedge clk);
    for (b = 0; b < WORD_BITS; b++) begin
      rx_i = w[b];
      repeat (CLK_PER_SAMPLE) @(negedge clk);
    end
    rx_i = stop_bit;
    repeat (CLK_PER_SAMPLE) @(negedge clk);
    // Idle gap so the word is forwarded before the next frame
    rx_i = 1'b1;
    repeat (2 * CLK_PER_SAMPLE) @(negedge clk);
  endtask

  task automatic run_command(input logic [CMD_WORDS*WORD_BITS-1:0] c);
    logic [WORD_BITS-1:0] exp_word;
    logic [WORD_BITS-1:0] got_word;
    int w;
    int b;
    int n;
    int t0;
    assert (tx_rdy_o) else report_failure("transmitter busy before a new command");
    tx_stb_i  = 1'b1;
    tx_data_i = c;
    @(negedge clk);
    // Fresh data after acceptance must not reach the line
    tx_stb_i  = 1'b0;
    tx_data_i = random_cmd();
    n = 1;
    while (tx_o && n < 4) begin
      @(negedge clk);
      n++;
    end
    assert (!tx_o) else report_failure("no start bit after an accepted strobe");
    t0 = cyc;
    for (w = 0; w < CMD_WORDS; w++) begin
      exp_word = c[(CMD_WORDS-1-w)*WORD_BITS +: WORD_BITS];
      repeat ((w == 0) ? CLK_PER_SAMPLE / 2 : CLK_PER_SAMPLE) @(negedge clk);
      assert (tx_o == 1'b0) else report_mismatch("start bit", 64'd0, 64'(tx_o));
      for (b = 0; b < WORD_BITS; b++) begin
        repeat (CLK_PER_SAMPLE) @(negedge clk);
        got_word[b] = tx_o;
      end
      repeat (CLK_PER_SAMPLE) @(negedge clk);
      assert (tx_o == 1'b1) else report_mismatch("stop bit", 64'd1, 64'(tx_o));
      assert (got_word == exp_word)
        else report_mismatch("tx word", 64'(exp_word), 64'(got_word));
    end
    n = 0;
    while (!tx_rdy_o && n < 4 * CLK_PER_SAMPLE) begin
      @(negedge clk);
      n++;
    end
    assert (tx_rdy_o) else report_failure("tx_rdy_o did not return after the command");
    assert (cyc - t0 == CMD_CYCLES)
      else report_mismatch("command length", 64'(CMD_CYCLES), 64'(cyc - t0));
  endtask

  task automatic check_strobe_ignored();
    int n;
    tx_stb_i  = 1'b1;
    tx_data_i = random_cmd();
    @(negedge clk);
    tx_stb_i = 1'b0;
    for (n = 0; n < 3 * CLK_PER_SAMPLE; n++) begin
      assert (tx_o && tx_rdy_o) else report_failure("strobe accepted in XOFF state");
      @(negedge clk);
    end
  endtask

  task automatic wait_rx_drain();
    int n;
    n = 0;
    while (rx_exp.size() != 0 && n < 4 * CLK_PER_SAMPLE) begin
      @(negedge clk);
      n++;
    end
    assert (rx_exp.size() == 0) else report_failure("expected word never seen on rx_stb_o");
  endtask

  // Forwarded words arrive in order and flow characters never appear
  always @(negedge clk) begin
    logic [WORD_BITS:0] exp_rx;
    if (rst_in && rx_stb_o) begin
      assert (rx_exp.size() != 0) else report_failure("unexpected word on rx_stb_o");
      exp_rx = rx_exp.pop_front();
      assert ({rx_frame_err_o, rx_data_o} == exp_rx)
        else report_mismatch("rx word", 64'(exp_rx), 64'({rx_frame_err_o, rx_data_o}));
    end
  end

  initial begin
    clk       = 1'b0;
    rst_in    = 1'b0;
    tx_stb_i  = 1'b0;
    tx_data_i = '0;
    rx_i      = 1'b1;
    void'($urandom(32'ha836_0c22));

    test_name = "reset";
    repeat (16) @(negedge clk);
    rst_in = 1'b1;
    @(negedge clk);
    assert (tx_o == 1'b1) else report_mismatch("tx_o", 64'd1, 64'(tx_o));
    assert (tx_rdy_o == 1'b1) else report_mismatch("tx_rdy_o", 64'd1, 64'(tx_rdy_o));
    assert (rx_stb_o == 1'b0) else report_mismatch("rx_stb_o", 64'd0, 64'(rx_stb_o));

    test_name = "random commands";
    repeat (4) run_command(random_cmd());

    test_name = "random received words";
    for (i = 0; i < 8; i++) begin
      word = random_data_word();
      rx_exp.push_back({1'b0, word});
      drive_rx_word(word, 1'b1);
    end
    wait_rx_drain();

    test_name = "flow control";
    drive_rx_word(XOFF_WORD, 1'b1);
    check_strobe_ignored();
    drive_rx_word(XON_WORD, 1'b1);
    run_command(random_cmd());

    test_name = "frame error";
    word = WORD_BITS'($urandom);
    rx_exp.push_back({1'b1, word});
    drive_rx_word(word, 1'b0);
    rx_exp.push_back({1'b1, XOFF_WORD});
    drive_rx_word(XOFF_WORD, 1'b0);
    wait_rx_drain();
    run_command(random_cmd());

    test_name = "xoff during command";
    cmd = random_cmd();
    fork
      run_command(cmd);
      begin
        repeat (3 * CLK_PER_SAMPLE) @(negedge clk);
        drive_rx_word(XOFF_WORD, 1'b1);
      end
    join
    check_strobe_ignored();
    drive_rx_word(XON_WORD, 1'b1);
    run_command(random_cmd());

    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

// File: tuart.f
common/tuart_pkg.sv
common/flow_ctrl_if.sv
common/rx_byte_if.sv
tuart_rx/tuart_rx.sv
hdl/xon_xoff_decode.sv
tuart_tx/tuart_tx.sv
hdl/tuart_top.sv
sim/tuart_props.sv
sim/tuart_tb.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator and run it; a failing run exits nonzero
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tuart_tb -f tuart.f &&
./obj_dir/Vtuart_tb || exit 1
